// File: pic_pkg.sv
package pic_pkg;

    // Interrupt levels and bus width
    localparam int irq_count       = 8;
    localparam int irq_index_width = 3;
    localparam int bus_width       = 8;

    // One bit per level
    typedef logic [irq_count-1:0] irq_vector_t;

    // Level number
    typedef logic [irq_index_width-1:0] irq_index_t;

    localparam irq_vector_t mask_reset_value   = '1;
    localparam irq_index_t  rotate_reset_value = 3'd7;

    // OCW2 command codes on bus bits 7..5
    localparam logic [2:0] ocw2_clear_auto_rotate = 3'b000;
    localparam logic [2:0] ocw2_nonspecific_eoi   = 3'b001;
    localparam logic [2:0] ocw2_specific_eoi      = 3'b011;
    localparam logic [2:0] ocw2_set_auto_rotate   = 3'b100;
    localparam logic [2:0] ocw2_rotate_on_eoi     = 3'b101;

    // One write from the bus interface
    typedef struct packed {
        logic [bus_width-1:0] data;
        logic                 icw1;
        logic                 icw2_4;
        logic                 ocw1;
        logic                 ocw2;
        logic                 ocw3;
    } bus_write_t;

    // Write events seen by the acknowledge and interrupt blocks
    typedef struct packed {
        logic [bus_width-1:0] data;
        logic                 icw1;
        logic                 ocw2_accepted;
    } cmd_write_t;

    // Programmed operating mode
    typedef struct packed {
        logic        ltim;
        logic        aeoi;
        logic        auto_rotate;
        logic        en_rd_reg;
        logic        read_isr_or_irr;
        irq_vector_t interrupt_mask;
    } mode_t;

    // Acknowledge progress
    typedef struct packed {
        logic        latch_in_service;
        logic        end_of_ack;
        irq_vector_t ack_interrupt;
    } ack_status_t;

endpackage

// File: pic_command_regs.sv
`timescale 1ns/1ns

module pic_command_regs (
    input  logic                clk,
    input  logic                reset,
    input  pic_pkg::bus_write_t bus,
    output pic_pkg::cmd_write_t cmd,
    output pic_pkg::mode_t      mode
);

    typedef enum logic [1:0] {
        cmd_ready,
        write_icw2,
        write_icw3,
        write_icw4
    } cmd_state_t;

    cmd_state_t state;
    cmd_state_t state_next;

    // ICW1 fields that steer the sequence
    logic sngl;
    logic ic4;

    logic icw4_write;
    logic ocw1_accepted;
    logic ocw2_accepted;
    logic ocw3_accepted;

    logic                 ltim;
    logic                 aeoi;
    logic                 auto_rotate;
    logic                 en_rd_reg;
    logic                 read_isr_or_irr;
    pic_pkg::irq_vector_t interrupt_mask;

    // Initialization sequence
    always_comb begin
        state_next = state;
        if (bus.icw1) begin
            state_next = write_icw2;
        end else if (bus.icw2_4) begin
            case (state)
                write_icw2: begin
                    if (!sngl)
                        state_next = write_icw3;
                    else if (ic4)
                        state_next = write_icw4;
                    else
                        state_next = cmd_ready;
                end
                write_icw3: begin
                    state_next = ic4 ? write_icw4 : cmd_ready;
                end
                default: begin
                    state_next = cmd_ready;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= cmd_ready;
        else
            state <= state_next;
    end

    assign icw4_write    = (state == write_icw4) && bus.icw2_4;
    // OCWs only count once initialization is done
    assign ocw1_accepted = (state == cmd_ready) && bus.ocw1;
    assign ocw2_accepted = (state == cmd_ready) && bus.ocw2;
    assign ocw3_accepted = (state == cmd_ready) && bus.ocw3;

    always_ff @(posedge clk) begin
        if (reset) begin
            ltim <= 1'b0;
            sngl <= 1'b0;
            ic4  <= 1'b0;
        end else if (bus.icw1) begin
            ltim <= bus.data[3];
            sngl <= bus.data[1];
            ic4  <= bus.data[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || bus.icw1)
            aeoi <= 1'b0;
        else if (icw4_write)
            aeoi <= bus.data[1];
    end

    // Mask register
    always_ff @(posedge clk) begin
        if (reset || bus.icw1)
            interrupt_mask <= pic_pkg::mask_reset_value;
        else if (ocw1_accepted)
            interrupt_mask <= bus.data;
    end

    always_ff @(posedge clk) begin
        if (reset || bus.icw1) begin
            auto_rotate <= 1'b0;
        end else if (ocw2_accepted) begin
            if (bus.data[7:5] == pic_pkg::ocw2_set_auto_rotate)
                auto_rotate <= 1'b1;
            else if (bus.data[7:5] == pic_pkg::ocw2_clear_auto_rotate)
                auto_rotate <= 1'b0;
        end
    end

    // Read register select
    always_ff @(posedge clk) begin
        if (reset || bus.icw1) begin
            en_rd_reg       <= 1'b1;
            read_isr_or_irr <= 1'b0;
        end else if (ocw3_accepted) begin
            en_rd_reg       <= bus.data[1];
            read_isr_or_irr <= bus.data[0];
        end
    end

    assign cmd  = '{data: bus.data, icw1: bus.icw1, ocw2_accepted: ocw2_accepted};
    assign mode = '{ltim: ltim, aeoi: aeoi, auto_rotate: auto_rotate,
                    en_rd_reg: en_rd_reg, read_isr_or_irr: read_isr_or_irr,
                    interrupt_mask: interrupt_mask};

    // Bus decoder never raises ICW1 together with an OCW
    icw1_ocw_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(bus.icw1 && (bus.ocw1 || bus.ocw2 || bus.ocw3)));

endmodule

// File: pic_ack_sequencer.sv
`timescale 1ns/1ns

module pic_ack_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inta_n,
    input  pic_pkg::irq_vector_t interrupt,
    input  logic                 icw1,
    input  logic                 ocw2_accepted,
    output pic_pkg::ack_status_t status,
    output logic                 freeze
);

    typedef enum logic [1:0] {
        ack_ready,
        ack_1,
        ack_2
    } ack_state_t;

    ack_state_t state;
    ack_state_t state_next;

    logic prev_inta_n;
    logic inta_fall;
    logic inta_rise;

    logic                 latch_in_service;
    logic                 end_of_ack;
    pic_pkg::irq_vector_t ack_interrupt;

    // INTA_n edges
    always_ff @(posedge clk) begin
        if (reset)
            prev_inta_n <= 1'b1;
        else
            prev_inta_n <= inta_n;
    end

    assign inta_fall = prev_inta_n && !inta_n;
    assign inta_rise = !prev_inta_n && inta_n;

    always_comb begin
        state_next = state;
        case (state)
            ack_ready: begin
                // An OCW2 in the same cycle holds off the acknowledge
                if (inta_fall && !ocw2_accepted)
                    state_next = ack_1;
            end
            ack_1: begin
                if (inta_rise)
                    state_next = ack_2;
            end
            ack_2: begin
                if (inta_rise)
                    state_next = ack_ready;
            end
            default: begin
                state_next = ack_ready;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || icw1)
            state <= ack_ready;
        else
            state <= state_next;
    end

    assign latch_in_service = !icw1 && (state == ack_ready) && (state_next != ack_ready);
    assign end_of_ack       = (state != ack_ready) && (state_next == ack_ready);

    // Acknowledged interrupt buffer
    always_ff @(posedge clk) begin
        if (reset || icw1)
            ack_interrupt <= '0;
        else if (end_of_ack)
            ack_interrupt <= '0;
        else if (latch_in_service)
            ack_interrupt <= interrupt;
    end

    always_ff @(posedge clk) begin
        if (reset)
            freeze <= 1'b1;
        else
            freeze <= (state_next != ack_ready);
    end

    assign status = '{latch_in_service: latch_in_service, end_of_ack: end_of_ack,
                      ack_interrupt: ack_interrupt};

    // Priority logic upstream hands over a single level
    ack_interrupt_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(ack_interrupt));

endmodule

// File: pic_interrupt_control.sv
`timescale 1ns/1ns

module pic_interrupt_control (
    input  logic                 clk,
    input  logic                 reset,
    input  pic_pkg::cmd_write_t  cmd,
    input  pic_pkg::mode_t       mode,
    input  pic_pkg::ack_status_t status,
    input  pic_pkg::irq_vector_t interrupt,
    input  pic_pkg::irq_vector_t highest_level_in_service,
    output logic                 int_req,
    output pic_pkg::irq_vector_t eoi,
    output pic_pkg::irq_index_t  priority_rotate,
    output pic_pkg::irq_vector_t clear_interrupt_request
);

    logic rotate_on_eoi;
    logic auto_rotate_now;

    function automatic pic_pkg::irq_vector_t level_to_vector(input pic_pkg::irq_index_t level);
        pic_pkg::irq_vector_t vector;
        vector        = '0;
        vector[level] = 1'b1;
        return vector;
    endfunction

    // Lowest set level, 7 when nothing is set
    function automatic pic_pkg::irq_index_t lowest_level(input pic_pkg::irq_vector_t vector);
        pic_pkg::irq_index_t level;
        level = pic_pkg::rotate_reset_value;
        for (int i = pic_pkg::irq_count - 1; i >= 0; i--) begin
            if (vector[i])
                level = pic_pkg::irq_index_t'(i);
        end
        return level;
    endfunction

    // End of interrupt
    always_comb begin
        eoi = '0;
        if (cmd.icw1) begin
            eoi = '1;
        end else if (mode.aeoi && status.end_of_ack) begin
            eoi = status.ack_interrupt;
        end else if (cmd.ocw2_accepted) begin
            if (cmd.data[6:5] == pic_pkg::ocw2_nonspecific_eoi[1:0])
                eoi = highest_level_in_service;
            else if (cmd.data[6:5] == pic_pkg::ocw2_specific_eoi[1:0])
                eoi = level_to_vector(cmd.data[2:0]);
        end
    end

    assign auto_rotate_now = mode.auto_rotate && status.end_of_ack;
    assign rotate_on_eoi   = cmd.ocw2_accepted &&
                             (cmd.data[7:5] == pic_pkg::ocw2_rotate_on_eoi);

    always_ff @(posedge clk) begin
        if (reset || cmd.icw1)
            priority_rotate <= pic_pkg::rotate_reset_value;
        else if (auto_rotate_now)
            priority_rotate <= lowest_level(status.ack_interrupt);
        else if (rotate_on_eoi)
            priority_rotate <= lowest_level(highest_level_in_service);
    end

    // INT stays up until the acknowledge ends with nothing pending
    always_ff @(posedge clk) begin
        if (reset || cmd.icw1)
            int_req <= 1'b0;
        else if (interrupt != '0)
            int_req <= 1'b1;
        else if (status.end_of_ack)
            int_req <= 1'b0;
    end

    always_comb begin
        if (cmd.icw1)
            clear_interrupt_request = '1;
        else if (status.latch_in_service)
            clear_interrupt_request = interrupt;
        else
            clear_interrupt_request = '0;
    end

    // In-service logic upstream names one level at a time
    eoi_single_level: assert property (@(posedge clk) disable iff (reset)
        !cmd.icw1 |-> $onehot0(eoi));

endmodule

// File: pic_control_logic.sv
`timescale 1ns/1ns

module pic_control_logic (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [pic_pkg::bus_width-1:0] internal_bus,
    input  logic                          icw_1,
    input  logic                          icw_2_4,
    input  logic                          ocw_1,
    input  logic                          ocw_2,
    input  logic                          ocw_3,
    input  logic                          inta_n,
    input  pic_pkg::irq_vector_t          interrupt,
    input  pic_pkg::irq_vector_t          highest_level_in_service,
    output logic                          int_req,
    output logic                          ltim,
    output logic                          en_rd_reg,
    output logic                          read_isr_or_irr,
    output logic                          freeze,
    output pic_pkg::irq_vector_t          interrupt_mask,
    output pic_pkg::irq_vector_t          eoi,
    output pic_pkg::irq_vector_t          clear_interrupt_request,
    output pic_pkg::irq_index_t           priority_rotate
);

    pic_pkg::bus_write_t  bus;
    pic_pkg::cmd_write_t  cmd;
    pic_pkg::mode_t       mode;
    pic_pkg::ack_status_t status;

    assign bus = '{data: internal_bus, icw1: icw_1, icw2_4: icw_2_4,
                   ocw1: ocw_1, ocw2: ocw_2, ocw3: ocw_3};

    pic_command_regs i_pic_command_regs (
        .clk   (clk),
        .reset (reset),
        .bus   (bus),
        .cmd   (cmd),
        .mode  (mode)
    );

    pic_ack_sequencer i_pic_ack_sequencer (
        .clk           (clk),
        .reset         (reset),
        .inta_n        (inta_n),
        .interrupt     (interrupt),
        .icw1          (cmd.icw1),
        .ocw2_accepted (cmd.ocw2_accepted),
        .status        (status),
        .freeze        (freeze)
    );

    pic_interrupt_control i_pic_interrupt_control (
        .clk                      (clk),
        .reset                    (reset),
        .cmd                      (cmd),
        .mode                     (mode),
        .status                   (status),
        .interrupt                (interrupt),
        .highest_level_in_service (highest_level_in_service),
        .int_req                  (int_req),
        .eoi                      (eoi),
        .priority_rotate          (priority_rotate),
        .clear_interrupt_request  (clear_interrupt_request)
    );

    assign ltim            = mode.ltim;
    assign en_rd_reg       = mode.en_rd_reg;
    assign read_isr_or_irr = mode.read_isr_or_irr;
    assign interrupt_mask  = mode.interrupt_mask;

endmodule

// File: tb_pic_control_logic.sv
`timescale 1ns/1ns

module tb_pic_control_logic;

    localparam int clk_period = 8;
    // Sum of the per-step cycle counts in the stimulus below
    localparam int stimulus_cycles = 122;

    // Strobe order is {icw_1, icw_2_4, ocw_1, ocw_2, ocw_3}
    localparam logic [4:0] icw1_write   = 5'b10000;
    localparam logic [4:0] icw2_4_write = 5'b01000;
    localparam logic [4:0] ocw1_write   = 5'b00100;
    localparam logic [4:0] ocw2_write   = 5'b00010;
    localparam logic [4:0] ocw3_write   = 5'b00001;

    logic                 clk;
    logic                 reset;
    logic [7:0]           internal_bus;
    logic                 icw_1;
    logic                 icw_2_4;
    logic                 ocw_1;
    logic                 ocw_2;
    logic                 ocw_3;
    logic                 inta_n;
    pic_pkg::irq_vector_t interrupt;
    pic_pkg::irq_vector_t highest_level_in_service;
    logic                 int_req;
    logic                 ltim;
    logic                 en_rd_reg;
    logic                 read_isr_or_irr;
    logic                 freeze;
    pic_pkg::irq_vector_t interrupt_mask;
    pic_pkg::irq_vector_t eoi;
    pic_pkg::irq_vector_t clear_interrupt_request;
    pic_pkg::irq_index_t  priority_rotate;

    int seed = 32'h77e6_6aae;
    int value_errors = 0;
    int reset_errors = 0;

    // Expected state: init sequence 0 ready, 1 ICW2, 2 ICW3, 3 ICW4
    logic [1:0] seq_state;
    logic [1:0] ack_step;
    logic [1:0] next_step;
    logic       exp_sngl;
    logic       exp_ic4;
    logic       exp_ltim;
    logic       exp_aeoi;
    logic       exp_auto_rotate;
    logic       exp_en_rd;
    logic       exp_read_sel;
    logic [7:0] exp_mask;
    logic       prev_inta;
    logic [7:0] exp_ack_vec;
    logic       exp_freeze;
    logic       exp_int_req;
    logic [2:0] exp_rotate;
    logic       ocw2_ok;
    logic       inta_fell;
    logic       inta_rose;
    logic       exp_latch;
    logic       exp_end;
    logic [7:0] exp_eoi;
    logic [7:0] exp_clear;

    pic_control_logic i_pic_control_logic (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [2:0] first_level(input logic [7:0] vec);
        for (int i = 0; i < 8; i++) begin
            if (vec[i])
                return 3'(i);
        end
        return 3'd7;
    endfunction

    always_comb begin
        ocw2_ok   = ocw_2 && (seq_state == 2'd0);
        inta_fell = prev_inta && !inta_n;
        inta_rose = !prev_inta && inta_n;
        next_step = ack_step;
        if (ack_step == 2'd0 && inta_fell && !ocw2_ok)
            next_step = 2'd1;
        else if (ack_step == 2'd1 && inta_rose)
            next_step = 2'd2;
        else if (ack_step == 2'd2 && inta_rose)
            next_step = 2'd0;
        exp_latch = !icw_1 && (ack_step == 2'd0) && (next_step != 2'd0);
        exp_end   = (ack_step == 2'd2) && inta_rose;
        exp_eoi   = 8'h00;
        if (icw_1)
            exp_eoi = 8'hff;
        else if (exp_aeoi && exp_end)
            exp_eoi = exp_ack_vec;
        else if (ocw2_ok && internal_bus[6:5] == 2'b01)
            exp_eoi = highest_level_in_service;
        else if (ocw2_ok && internal_bus[6:5] == 2'b11)
            exp_eoi = 8'd1 << internal_bus[2:0];
        exp_clear = icw_1 ? 8'hff : (exp_latch ? interrupt : 8'h00);
    end

    always_ff @(posedge clk) begin
        if (reset || icw_1) begin
            seq_state       <= reset ? 2'd0 : 2'd1;
            exp_aeoi        <= 1'b0;
            exp_auto_rotate <= 1'b0;
            exp_mask        <= 8'hff;
            exp_en_rd       <= 1'b1;
            exp_read_sel    <= 1'b0;
            ack_step        <= 2'd0;
            exp_ack_vec     <= 8'h00;
            exp_int_req     <= 1'b0;
            exp_rotate      <= 3'd7;
        end else begin
            if (icw_2_4) begin
                if (seq_state == 2'd1)
                    seq_state <= !exp_sngl ? 2'd2 : (exp_ic4 ? 2'd3 : 2'd0);
                else if (seq_state == 2'd2)
                    seq_state <= exp_ic4 ? 2'd3 : 2'd0;
                else
                    seq_state <= 2'd0;
                if (seq_state == 2'd3)
                    exp_aeoi <= internal_bus[1];
            end
            if (ocw_1 && seq_state == 2'd0)
                exp_mask <= internal_bus;
            if (ocw_3 && seq_state == 2'd0) begin
                exp_en_rd    <= internal_bus[1];
                exp_read_sel <= internal_bus[0];
            end
            if (ocw2_ok && internal_bus[7:5] == 3'b100)
                exp_auto_rotate <= 1'b1;
            else if (ocw2_ok && internal_bus[7:5] == 3'b000)
                exp_auto_rotate <= 1'b0;
            ack_step <= next_step;
            if (exp_end)
                exp_ack_vec <= 8'h00;
            else if (exp_latch)
                exp_ack_vec <= interrupt;
            if (interrupt != 8'h00)
                exp_int_req <= 1'b1;
            else if (exp_end)
                exp_int_req <= 1'b0;
            if (exp_auto_rotate && exp_end)
                exp_rotate <= first_level(exp_ack_vec);
            else if (ocw2_ok && internal_bus[7:5] == 3'b101)
                exp_rotate <= first_level(highest_level_in_service);
        end
        // ICW1 fields survive a re-initialization until the next ICW1
        if (reset) begin
            exp_sngl <= 1'b0;
            exp_ic4  <= 1'b0;
            exp_ltim <= 1'b0;
        end else if (icw_1) begin
            exp_sngl <= internal_bus[1];
            exp_ic4  <= internal_bus[0];
            exp_ltim <= internal_bus[3];
        end
        prev_inta  <= reset ? 1'b1 : inta_n;
        exp_freeze <= reset ? 1'b1 : (next_step != 2'd0);
    end

    task automatic report_value(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        value_errors++;
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    endtask

    check_eoi: assert property (@(posedge clk) disable iff (reset) eoi == exp_eoi)
        else report_value("eoi", $sampled(exp_eoi), $sampled(eoi));
    check_clear: assert property (@(posedge clk) disable iff (reset)
        clear_interrupt_request == exp_clear)
        else report_value("clear", $sampled(exp_clear), $sampled(clear_interrupt_request));
    check_int_req: assert property (@(posedge clk) disable iff (reset) int_req == exp_int_req)
        else report_value("int_req", 8'($sampled(exp_int_req)), 8'($sampled(int_req)));
    check_rotate: assert property (@(posedge clk) disable iff (reset)
        priority_rotate == exp_rotate)
        else report_value("rotate", 8'($sampled(exp_rotate)), 8'($sampled(priority_rotate)));
    check_mask: assert property (@(posedge clk) disable iff (reset) interrupt_mask == exp_mask)
        else report_value("mask", $sampled(exp_mask), $sampled(interrupt_mask));
    check_freeze: assert property (@(posedge clk) disable iff (reset) freeze == exp_freeze)
        else report_value("freeze", 8'($sampled(exp_freeze)), 8'($sampled(freeze)));
    check_mode: assert property (@(posedge clk) disable iff (reset)
        {ltim, en_rd_reg, read_isr_or_irr} == {exp_ltim, exp_en_rd, exp_read_sel})
        else report_value("ltim/rd/sel", 8'($sampled({exp_ltim, exp_en_rd, exp_read_sel})),
                          8'($sampled({ltim, en_rd_reg, read_isr_or_irr})));
    check_reset: assert property (@(posedge clk) $fell(reset) |->
        !int_req && interrupt_mask == 8'hff && priority_rotate == 3'd7 && en_rd_reg &&
        eoi == 8'h00 && clear_interrupt_request == 8'h00)
        else begin
            reset_errors++;
            $display("Outputs are not at their rest values after reset");
        end

    task automatic write_bus(input logic [4:0] strobe, input logic [7:0] data);
        @(posedge clk);
        internal_bus <= data;
        {icw_1, icw_2_4, ocw_1, ocw_2, ocw_3} <= strobe;
        @(posedge clk);
        {icw_1, icw_2_4, ocw_1, ocw_2, ocw_3} <= 5'b00000;
    endtask

    // OCW1 in the middle is expected to be ignored
    task automatic initialize(input logic [7:0] icw1_byte, input logic [7:0] icw4_byte);
        write_bus(icw1_write, icw1_byte);
        write_bus(ocw1_write, 8'h00);
        write_bus(icw2_4_write, 8'h08);
        if (!icw1_byte[1])
            write_bus(icw2_4_write, 8'h04);
        if (icw1_byte[0])
            write_bus(icw2_4_write, icw4_byte);
    endtask

    task automatic acknowledge();
        logic [31:0] pick;
        pick = $random(seed);
        @(posedge clk);
        interrupt <= 8'd1 << pick[2:0];
        repeat (2) @(posedge clk);
        inta_n <= 1'b0;
        repeat (2) @(posedge clk);
        inta_n <= 1'b1;
        @(posedge clk);
        inta_n    <= 1'b0;
        interrupt <= 8'h00;
        @(posedge clk);
        inta_n <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // INTA_n falls in the same cycle as an accepted OCW2
    task automatic collide_ocw2();
        @(posedge clk);
        interrupt    <= 8'h04;
        internal_bus <= 8'h20;
        ocw_2        <= 1'b1;
        inta_n       <= 1'b0;
        @(posedge clk);
        ocw_2     <= 1'b0;
        interrupt <= 8'h00;
        @(posedge clk);
        inta_n <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        reset                    = 1'b1;
        internal_bus             = 8'h00;
        {icw_1, icw_2_4, ocw_1, ocw_2, ocw_3} = 5'b00000;
        inta_n                   = 1'b1;
        interrupt                = 8'h00;
        highest_level_in_service = 8'h00;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        initialize(8'h13, 8'h01);
        initialize(8'h1b, 8'h00);
        initialize(8'h11, 8'h01);
        initialize(8'h10, 8'h00);
        write_bus(ocw1_write, 8'h5a);
        acknowledge();
        // Automatic EOI with automatic rotation
        initialize(8'h13, 8'h03);
        write_bus(ocw2_write, 8'h80);
        acknowledge();
        acknowledge();
        @(posedge clk);
        highest_level_in_service <= 8'h10;
        write_bus(ocw2_write, 8'h20);
        write_bus(ocw2_write, 8'h63);
        write_bus(ocw2_write, 8'ha0);
        write_bus(ocw2_write, 8'h00);
        // Rotation holds now that auto-rotate is off
        acknowledge();
        highest_level_in_service <= 8'h00;
        write_bus(ocw2_write, 8'ha0);
        collide_ocw2();
        write_bus(ocw3_write, 8'h0b);
        write_bus(ocw3_write, 8'h08);
        write_bus(ocw3_write, 8'h0a);
        repeat (4) @(posedge clk);
        $display("Errors: %0d value, %0d reset", value_errors, reset_errors);
        if (value_errors == 0 && reset_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial begin
        #(20 * stimulus_cycles * clk_period);
        $display("Watchdog expired before the stimulus finished");
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: verilog.f
pic_pkg.sv
pic_command_regs.sv
pic_ack_sequencer.sv
pic_interrupt_control.sv
pic_control_logic.sv
tb_pic_control_logic.sv

// File: Makefile
TOP := tb_pic_control_logic

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
